//--- hw/cache_settings.svh
// ======================================
// Cache geometry for the 2-way write-back cache
// ======================================
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Word address seen by the CPU and by main memory
`define CACHE_ADDR_W 16

// Data word carried on every bus
`define CACHE_WORD_W 32

// Words in one cache line, moved as one burst
`define CACHE_LINE_WORDS 4

// Sets per way
`define CACHE_SETS 8

// Address split as tag, index and word offset from the top down
`define CACHE_OFFSET_W 2
`define CACHE_INDEX_W 3
`define CACHE_TAG_W 11

`endif

//--- hw/cache_pkg.sv
// ======================================
// Shared types of the 2-way cache
// ======================================
`include "cache_settings.svh"

package cache_pkg;

	// Word address from the CPU, also used towards memory
	typedef logic [`CACHE_ADDR_W-1:0] addr_t;

	// One data word
	typedef logic [`CACHE_WORD_W-1:0] word_t;

	// A whole line, element 0 is the low word of the line
	typedef logic [`CACHE_LINE_WORDS-1:0][`CACHE_WORD_W-1:0] line_t;

	// Fields cut out of an address
	typedef logic [`CACHE_TAG_W-1:0] tag_t;
	typedef logic [`CACHE_INDEX_W-1:0] index_t;
	typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

	// Contents of one tag RAM entry
	// The valid bit sits on top, then dirty, then the tag itself
	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} tag_entry_t;

	// Way number, two ways in this cache
	typedef logic way_t;

endpackage

//--- hw/lookup_if.sv
// ======================================
// Tag lookup results, decode to control
// ======================================
`timescale 1ns/1ns

interface lookup_if;

	// Set when one of the two ways holds the requested tag
	logic hit;

	// Way that matched, only meaningful with hit
	cache_pkg::way_t hit_way;

	// Way to replace on a miss
	// An invalid way is taken first, otherwise the LRU way
	cache_pkg::way_t victim_way;

	// The victim needs a write-back before the fill
	logic victim_dirty;

	// Tag of the victim, forms the write-back line address
	cache_pkg::tag_t victim_tag;

	// Tag decode produces the results
	modport decode (output hit, hit_way, victim_way, victim_dirty, victim_tag);

	// Cache control samples them in its lookup state
	modport control (input hit, hit_way, victim_way, victim_dirty, victim_tag);

endinterface

//--- hw/way_ram.sv
// ======================================
// One way of storage, one entry per set
// ======================================
`timescale 1ns/1ns
`include "cache_settings.svh"

module way_ram #(
	parameter type payload_t = logic
) (
	input logic clock,
	input logic reset_n,
	input cache_pkg::index_t index,
	input logic write_enable,
	input payload_t write_data,
	output payload_t read_data
);

	payload_t entries [`CACHE_SETS];

	// Read is registered, so data follows the index by one clock
	// A write and a read of the same set on one edge return the old entry
	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			// Clearing the entries marks every tag invalid
			for (int i = 0; i < `CACHE_SETS; i++)
				entries[i] <= '0;
			read_data <= '0;
		end
		else
		begin
			if (write_enable)
				entries[index] <= write_data;
			read_data <= entries[index];
		end
	end

endmodule

//--- hw/tag_decode.sv
// ======================================
// Tag compare, hit way and victim choice
// ======================================
`timescale 1ns/1ns

module tag_decode (
	input cache_pkg::tag_t tag,
	input cache_pkg::tag_entry_t entry_0,
	input cache_pkg::tag_entry_t entry_1,
	input logic lru,
	lookup_if.decode lookup
);

	logic hit_0;
	logic hit_1;
	cache_pkg::way_t victim;
	cache_pkg::tag_entry_t victim_entry;

	// A way hits only when its entry is valid and the tags agree
	assign hit_0 = entry_0.valid && (entry_0.tag == tag);
	assign hit_1 = entry_1.valid && (entry_1.tag == tag);

	assign lookup.hit = hit_0 || hit_1;

	// Both ways never hold the same tag, so way 1 only wins alone
	assign lookup.hit_way = hit_1;

	// Victim choice for a miss
	always_comb
	begin
		if (!entry_0.valid)
		begin
			// Empty way 0 is filled first
			victim = 1'b0;
		end
		else if (!entry_1.valid)
		begin
			victim = 1'b1;
		end
		else
		begin
			// Both ways are in use
			// The LRU bit names the way touched longest ago
			victim = lru;
		end
	end

	assign victim_entry = victim ? entry_1 : entry_0;

	assign lookup.victim_way = victim;

	// An invalid victim never needs a write-back, even with stale dirty bits
	assign lookup.victim_dirty = victim_entry.valid && victim_entry.dirty;

	// Upper part of the line address for the write-back burst
	assign lookup.victim_tag = victim_entry.tag;

endmodule

//--- hw/line_buffer.sv
// ======================================
// Line buffer: fill, write-back and word merge
// ======================================
`timescale 1ns/1ns
`include "cache_settings.svh"

module line_buffer (
	input logic clock,
	input logic reset_n,
	input cache_pkg::line_t line_0,
	input cache_pkg::line_t line_1,
	input cache_pkg::way_t hit_way,
	input cache_pkg::offset_t offset,
	input cache_pkg::word_t cpu_word,
	input logic capture_word,
	input logic capture_victim,
	input cache_pkg::way_t victim_way,
	input logic shift_out,
	input logic fill_shift,
	input cache_pkg::word_t fill_word,
	input logic use_fill,
	input logic merge_write,
	input logic load_read_word,
	output cache_pkg::line_t new_line,
	output cache_pkg::word_t out_word,
	output cache_pkg::word_t read_word
);

	// Victim line on its way out to memory
	cache_pkg::line_t wb_line;

	// Fill line, assembled from the memory burst
	cache_pkg::line_t fill_line;

	// CPU write data, held for the whole access
	cache_pkg::word_t write_word;

	always_ff @(posedge clock)
	begin
		// Victim is taken while the RAM outputs still show its set
		if (capture_victim)
			wb_line <= victim_way ? line_1 : line_0;
		else if (shift_out)
			wb_line <= {cache_pkg::word_t'(0), wb_line[`CACHE_LINE_WORDS-1:1]};

		// Words arrive low word first and move down one slot per beat
		// After the fourth beat word 0 sits in the lowest slot
		if (fill_shift)
			fill_line <= {fill_word, fill_line[`CACHE_LINE_WORDS-1:1]};

		if (capture_word)
			write_word <= cpu_word;
	end

	// The lowest slot always carries the current write-back beat
	assign out_word = wb_line[0];

	// Line written back into the RAM on completion
	always_comb
	begin
		if (use_fill)
			new_line = fill_line;
		else
			new_line = hit_way ? line_1 : line_0;

		// A write replaces one word and leaves the rest of the line alone
		if (merge_write)
			new_line[offset] = write_word;
	end

	// Word returned to the CPU, kept until the next read completes
	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
			read_word <= '0;
		else if (load_read_word)
			read_word <= new_line[offset];
	end

endmodule

//--- hw/cache_control.sv
// ======================================
// Cache controller FSM with LRU bits and strobes
// ======================================
`timescale 1ns/1ns
`include "cache_settings.svh"

module cache_control (
	input logic clock,
	input logic reset_n,
	input logic rd_cpu,
	input logic wr_cpu,
	input cache_pkg::addr_t addr_cpu,
	lookup_if.control lookup,
	input logic ready_mem,
	output logic lru,
	output cache_pkg::index_t ram_index,
	output logic [1:0] tag_write,
	output logic [1:0] data_write,
	output cache_pkg::tag_entry_t new_entry,
	output cache_pkg::way_t active_way,
	output cache_pkg::offset_t word_offset,
	output logic capture_word,
	output logic capture_victim,
	output logic shift_out,
	output logic fill_shift,
	output logic use_fill,
	output logic merge_write,
	output logic load_read_word,
	output cache_pkg::addr_t addr_mem,
	output logic rd_mem,
	output logic wr_mem,
	output logic stall_cpu
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_WRITEBACK,
		ST_FILL_REQ,
		ST_FILL_WAIT,
		ST_FILL_COLLECT,
		ST_UPDATE
	} state_t;

	state_t state;

	// Request held for the whole access
	cache_pkg::addr_t addr_q;
	logic is_write;

	// Lookup outcome kept past the lookup cycle
	logic hit_q;
	cache_pkg::tag_t victim_tag_q;

	// Beat count inside a burst
	logic [`CACHE_OFFSET_W-1:0] beat;

	// One bit per set, naming the least recently used way
	logic [`CACHE_SETS-1:0] lru_bits;

	logic take;
	logic ram_write;
	cache_pkg::tag_t tag_q;
	cache_pkg::index_t index_q;

	assign tag_q = addr_q[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
	assign index_q = addr_q[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign word_offset = addr_q[`CACHE_OFFSET_W-1:0];

	// New requests are only looked at while idle
	assign take = (state == ST_IDLE) && (rd_cpu || wr_cpu);

	// Idle presents the incoming index so the RAMs answer in the lookup cycle
	assign ram_index = (state == ST_IDLE) ?
		addr_cpu[`CACHE_OFFSET_W +: `CACHE_INDEX_W] : index_q;

	assign lru = lru_bits[index_q];

	// A read hit changes nothing in the RAMs, only the LRU bit moves
	assign ram_write = (state == ST_UPDATE) && (is_write || !hit_q);
	assign tag_write = ram_write ? (active_way ? 2'b10 : 2'b01) : 2'b00;
	assign data_write = tag_write;

	// Dirty follows the operation, so a clean fill clears it
	assign new_entry = '{valid: 1'b1, dirty: is_write, tag: tag_q};

	// Line buffer strobes
	assign capture_word = take;
	assign capture_victim = (state == ST_LOOKUP) && !lookup.hit;
	assign shift_out = wr_mem;
	assign fill_shift = ready_mem &&
		((state == ST_FILL_WAIT) || (state == ST_FILL_COLLECT));
	assign use_fill = !hit_q;
	assign merge_write = is_write;
	assign load_read_word = (state == ST_UPDATE) && !is_write;

	// Memory strobes only go out while the memory reports ready
	assign wr_mem = (state == ST_WRITEBACK) && ready_mem;
	assign rd_mem = (state == ST_FILL_REQ) && ready_mem;

	// Line addresses always carry a zero offset
	assign addr_mem = (state == ST_WRITEBACK) ?
		{victim_tag_q, index_q, cache_pkg::offset_t'(0)} :
		{tag_q, index_q, cache_pkg::offset_t'(0)};

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= ST_IDLE;
			addr_q <= '0;
			is_write <= 1'b0;
			hit_q <= 1'b0;
			active_way <= 1'b0;
			victim_tag_q <= '0;
			beat <= '0;
			lru_bits <= '0;
			stall_cpu <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (take)
					begin
						addr_q <= addr_cpu;
						// A read wins when both strobes come together
						is_write <= !rd_cpu;
						state <= ST_LOOKUP;
					end
				end
				ST_LOOKUP:
				begin
					stall_cpu <= 1'b1;
					hit_q <= lookup.hit;
					active_way <= lookup.hit ? lookup.hit_way : lookup.victim_way;
					victim_tag_q <= lookup.victim_tag;
					beat <= '0;
					if (lookup.hit)
						state <= ST_UPDATE;
					else if (lookup.victim_dirty)
						state <= ST_WRITEBACK;
					else
						state <= ST_FILL_REQ;
				end
				ST_WRITEBACK:
				begin
					// The count wraps to zero after the last beat
					if (ready_mem)
					begin
						beat <= beat + 1'b1;
						if (beat == '1)
							state <= ST_FILL_REQ;
					end
				end
				ST_FILL_REQ:
				begin
					if (ready_mem)
						state <= ST_FILL_WAIT;
				end
				ST_FILL_WAIT:
				begin
					// First ready after the request carries word 0
					if (ready_mem)
					begin
						beat <= 1;
						state <= ST_FILL_COLLECT;
					end
				end
				ST_FILL_COLLECT:
				begin
					if (ready_mem)
					begin
						beat <= beat + 1'b1;
						if (beat == '1)
							state <= ST_UPDATE;
					end
				end
				ST_UPDATE:
				begin
					// RAM write, LRU update and completion share this edge
					stall_cpu <= 1'b0;
					lru_bits[index_q] <= ~active_way;
					state <= ST_IDLE;
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

//--- hw/cache_2way.sv
// ======================================
// 2-way set-associative write-back cache
// ======================================
`timescale 1ns/1ns

module cache_2way (
	input logic clock,
	input logic reset_n,
	input logic rd_cpu,
	input logic wr_cpu,
	input cache_pkg::addr_t addr_cpu,
	input cache_pkg::word_t wdata_cpu,
	output cache_pkg::word_t rdata_cpu,
	output logic stall_cpu,
	output cache_pkg::addr_t addr_mem,
	output logic rd_mem,
	output logic wr_mem,
	output cache_pkg::word_t wdata_mem,
	input cache_pkg::word_t rdata_mem,
	input logic ready_mem
);

	cache_pkg::index_t ram_index;
	cache_pkg::tag_entry_t entry_0;
	cache_pkg::tag_entry_t entry_1;
	cache_pkg::tag_entry_t new_entry;
	cache_pkg::line_t line_0;
	cache_pkg::line_t line_1;
	cache_pkg::line_t new_line;
	logic [1:0] tag_write;
	logic [1:0] data_write;
	logic lru;
	cache_pkg::way_t active_way;
	cache_pkg::offset_t word_offset;
	logic capture_word;
	logic capture_victim;
	logic shift_out;
	logic fill_shift;
	logic use_fill;
	logic merge_write;
	logic load_read_word;

	lookup_if lookup_bus ();

	// Tag and data RAMs of both ways share one index
	way_ram #(.payload_t(cache_pkg::tag_entry_t)) tag_ram_0 (
		.clock(clock), .reset_n(reset_n), .index(ram_index),
		.write_enable(tag_write[0]), .write_data(new_entry), .read_data(entry_0));
	way_ram #(.payload_t(cache_pkg::tag_entry_t)) tag_ram_1 (
		.clock(clock), .reset_n(reset_n), .index(ram_index),
		.write_enable(tag_write[1]), .write_data(new_entry), .read_data(entry_1));
	way_ram #(.payload_t(cache_pkg::line_t)) data_ram_0 (
		.clock(clock), .reset_n(reset_n), .index(ram_index),
		.write_enable(data_write[0]), .write_data(new_line), .read_data(line_0));
	way_ram #(.payload_t(cache_pkg::line_t)) data_ram_1 (
		.clock(clock), .reset_n(reset_n), .index(ram_index),
		.write_enable(data_write[1]), .write_data(new_line), .read_data(line_1));

	// The entry being written carries the tag of the latched request
	tag_decode decode (
		.tag(new_entry.tag), .entry_0(entry_0), .entry_1(entry_1),
		.lru(lru), .lookup(lookup_bus.decode));

	cache_control execute (
		.clock(clock), .reset_n(reset_n), .rd_cpu(rd_cpu), .wr_cpu(wr_cpu),
		.addr_cpu(addr_cpu), .lookup(lookup_bus.control), .ready_mem(ready_mem),
		.lru(lru), .ram_index(ram_index), .tag_write(tag_write),
		.data_write(data_write), .new_entry(new_entry), .active_way(active_way),
		.word_offset(word_offset), .capture_word(capture_word),
		.capture_victim(capture_victim), .shift_out(shift_out),
		.fill_shift(fill_shift), .use_fill(use_fill), .merge_write(merge_write),
		.load_read_word(load_read_word), .addr_mem(addr_mem), .rd_mem(rd_mem),
		.wr_mem(wr_mem), .stall_cpu(stall_cpu));

	// Victim way comes straight from decode in the lookup cycle
	line_buffer result (
		.clock(clock), .reset_n(reset_n), .line_0(line_0), .line_1(line_1),
		.hit_way(active_way), .offset(word_offset), .cpu_word(wdata_cpu),
		.capture_word(capture_word), .capture_victim(capture_victim),
		.victim_way(lookup_bus.victim_way), .shift_out(shift_out),
		.fill_shift(fill_shift), .fill_word(rdata_mem), .use_fill(use_fill),
		.merge_write(merge_write), .load_read_word(load_read_word),
		.new_line(new_line), .out_word(wdata_mem), .read_word(rdata_cpu));

endmodule

//--- tb/mem_model.sv
// ======================================
// Main memory model with the burst handshake
// ======================================
`timescale 1ns/1ns
`include "cache_settings.svh"

module mem_model #(
	parameter int latency = 3
) (
	input logic clock,
	input logic reset_n,
	input cache_pkg::addr_t addr,
	input logic rd,
	input logic wr,
	input cache_pkg::word_t wdata,
	output cache_pkg::word_t rdata,
	output logic ready,
	output int read_count,
	output int write_count,
	output cache_pkg::addr_t last_write_addr
);

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_LATENCY,
		PH_SEND,
		PH_GAP
	} phase_t;

	// Whole address space, loaded by the testbench at time zero
	cache_pkg::word_t storage [2**`CACHE_ADDR_W];

	phase_t phase;
	logic [`CACHE_ADDR_W-`CACHE_OFFSET_W-1:0] fill_line;
	logic [`CACHE_OFFSET_W-1:0] beat;
	logic [`CACHE_OFFSET_W-1:0] write_beat;
	int wait_count;
	logic ready_next;
	cache_pkg::word_t rdata_next;

	// Requests are sampled on the rising edge, the same edge the cache acts on
	always @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			phase <= PH_IDLE;
			fill_line <= '0;
			beat <= '0;
			write_beat <= '0;
			wait_count <= 0;
			ready_next <= 1'b1;
			rdata_next <= '0;
			read_count <= 0;
			write_count <= 0;
			last_write_addr <= '0;
		end
		else
		begin
			case (phase)
				PH_IDLE:
				begin
					if (rd)
					begin
						// One read burst per rd pulse, ready drops right away
						fill_line <= addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W];
						read_count <= read_count + 1;
						wait_count <= latency;
						ready_next <= 1'b0;
						phase <= PH_LATENCY;
					end
					else if (wr)
					begin
						storage[{addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], write_beat}] <= wdata;
						write_beat <= write_beat + 1'b1;
						if (write_beat == '0)
							last_write_addr <= addr;
						// The fourth beat closes the burst and the memory rests a while
						if (write_beat == '1)
						begin
							write_count <= write_count + 1;
							wait_count <= 2;
							ready_next <= 1'b0;
							phase <= PH_GAP;
						end
					end
				end
				PH_LATENCY:
				begin
					if (wait_count <= 1)
					begin
						rdata_next <= storage[{fill_line, {`CACHE_OFFSET_W{1'b0}}}];
						ready_next <= 1'b1;
						beat <= '0;
						phase <= PH_SEND;
					end
					else
						wait_count <= wait_count - 1;
				end
				PH_SEND:
				begin
					// Exactly four ready cycles, words 0 to 3 in order
					if (beat == '1)
					begin
						ready_next <= 1'b0;
						wait_count <= 1;
						phase <= PH_GAP;
					end
					else
					begin
						beat <= beat + 1'b1;
						rdata_next <= storage[{fill_line, beat + 1'b1}];
					end
				end
				default:
				begin
					if (wait_count <= 1)
					begin
						ready_next <= 1'b1;
						phase <= PH_IDLE;
					end
					else
						wait_count <= wait_count - 1;
				end
			endcase
		end
	end

	// Outputs towards the cache change on the falling edge
	always @(negedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			ready <= 1'b1;
			rdata <= '0;
		end
		else
		begin
			ready <= ready_next;
			rdata <= rdata_next;
		end
	end

endmodule

//--- tb/cache_tb.sv
// ======================================
// Directed testbench for the 2-way cache
// ======================================
`timescale 1ns/1ns
`include "cache_settings.svh"

module cache_tb;

	// Each access takes at most about 30 cycles, so 2000 cycles cover every test with margin
	localparam int max_cycles = 2000;
	localparam int access_limit = 40;

	logic clock;
	logic reset_n;
	logic rd_cpu;
	logic wr_cpu;
	cache_pkg::addr_t addr_cpu;
	cache_pkg::word_t wdata_cpu;
	cache_pkg::word_t rdata_cpu;
	logic stall_cpu;
	cache_pkg::addr_t addr_mem;
	logic rd_mem;
	logic wr_mem;
	cache_pkg::word_t wdata_mem;
	cache_pkg::word_t rdata_mem;
	logic ready_mem;
	int read_count;
	int write_count;
	cache_pkg::addr_t last_write_addr;

	// What memory should hold, and what the CPU should read at each address
	cache_pkg::word_t mem_mirror [2**`CACHE_ADDR_W];
	cache_pkg::word_t cpu_view [2**`CACHE_ADDR_W];

	int error_count = 0;
	int check_total = 0;
	int cycle_count = 0;
	int reads_mark;
	int writes_mark;

	cache_2way UUT (
		.clock(clock), .reset_n(reset_n), .rd_cpu(rd_cpu), .wr_cpu(wr_cpu),
		.addr_cpu(addr_cpu), .wdata_cpu(wdata_cpu), .rdata_cpu(rdata_cpu),
		.stall_cpu(stall_cpu), .addr_mem(addr_mem), .rd_mem(rd_mem), .wr_mem(wr_mem),
		.wdata_mem(wdata_mem), .rdata_mem(rdata_mem), .ready_mem(ready_mem));

	mem_model memory (
		.clock(clock), .reset_n(reset_n), .addr(addr_mem), .rd(rd_mem), .wr(wr_mem),
		.wdata(wdata_mem), .rdata(rdata_mem), .ready(ready_mem),
		.read_count(read_count), .write_count(write_count),
		.last_write_addr(last_write_addr));

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// Watchdog over the whole run
	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles)
		begin
			$display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Address layout is tag, set index, word offset from the top down
	function automatic cache_pkg::addr_t make_addr(input cache_pkg::tag_t tag,
		input cache_pkg::index_t index, input cache_pkg::offset_t offset);
		return {tag, index, offset};
	endfunction

	task automatic check_word(input string test_name, input cache_pkg::word_t expected,
		input cache_pkg::word_t actual);
		check_total++;
		if (actual !== expected)
		begin
			error_count++;
			$display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	task automatic check_addr(input string test_name, input cache_pkg::addr_t expected,
		input cache_pkg::addr_t actual);
		check_total++;
		if (actual !== expected)
		begin
			error_count++;
			$display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	task automatic check_count(input string test_name, input int expected, input int actual);
		check_total++;
		if (actual != expected)
		begin
			error_count++;
			$display("CHECK FAILED %s: expected %0d, actual %0d", test_name, expected, actual);
		end
	endtask

	task automatic check_level(input string test_name, input logic expected,
		input logic actual);
		check_total++;
		if (actual !== expected)
		begin
			error_count++;
			$display("CHECK FAILED %s: expected %b, actual %b", test_name, expected, actual);
		end
	endtask

	task automatic fill_memory();
		logic [31:0] seed;
		cache_pkg::word_t value;
		seed = 32'h6a21;
		for (int a = 0; a < 2**`CACHE_ADDR_W; a++)
		begin
			seed = xorshift32(seed);
			// Folding in the address keeps every word tied to where it lives
			value = seed ^ {cache_pkg::addr_t'(a), cache_pkg::addr_t'(a)};
			memory.storage[a] = value;
			mem_mirror[a] = value;
			cpu_view[a] = value;
		end
	endtask

	// Entered on a falling edge with the cache idle and left on the falling edge after stall drops
	task automatic run_access(input logic is_write, input cache_pkg::addr_t addr,
		input cache_pkg::word_t data, output int stalled);
		int waited;
		stalled = 0;
		waited = 0;
		addr_cpu = addr;
		wdata_cpu = data;
		rd_cpu = !is_write;
		wr_cpu = is_write;
		@(negedge clock);
		rd_cpu = 1'b0;
		wr_cpu = 1'b0;
		// Stall rises one edge after the request is taken
		@(negedge clock);
		while (!stall_cpu && waited < access_limit)
		begin
			@(negedge clock);
			waited++;
		end
		while (stall_cpu && waited < access_limit)
		begin
			stalled++;
			@(negedge clock);
			waited++;
		end
		if (waited >= access_limit)
		begin
			error_count++;
			$display("Access to address %h did not complete in %0d cycles", addr, access_limit);
		end
	endtask

	task automatic read_check(input string test_name, input cache_pkg::addr_t addr,
		output int stalled);
		run_access(1'b0, addr, '0, stalled);
		check_word(test_name, cpu_view[addr], rdata_cpu);
	endtask

	task automatic write_word(input cache_pkg::addr_t addr, input cache_pkg::word_t data);
		int stalled;
		cpu_view[addr] = data;
		run_access(1'b1, addr, data, stalled);
	endtask

	task automatic mark_traffic();
		reads_mark = read_count;
		writes_mark = write_count;
	endtask

	// Read and write bursts since the last mark
	task automatic expect_traffic(input string test_name, input int reads, input int writes);
		check_count({test_name, " reads"}, reads, read_count - reads_mark);
		check_count({test_name, " writes"}, writes, write_count - writes_mark);
	endtask

	// A write-back copies the line the CPU last saw into memory
	task automatic expect_writeback(input string test_name, input cache_pkg::addr_t line_addr);
		cache_pkg::addr_t a;
		check_addr({test_name, " address"}, line_addr, last_write_addr);
		for (int i = 0; i < `CACHE_LINE_WORDS; i++)
		begin
			a = line_addr | cache_pkg::addr_t'(i);
			mem_mirror[a] = cpu_view[a];
			check_word({test_name, " memory"}, mem_mirror[a], memory.storage[a]);
		end
	endtask

	task automatic read_miss_clean();
		int stalled;
		mark_traffic();
		read_check("read miss", make_addr(11'd5, 3'd1, 2'd2), stalled);
		expect_traffic("read miss", 1, 0);
	endtask

	task automatic read_hit_repeat();
		int stalled;
		mark_traffic();
		read_check("read hit", make_addr(11'd5, 3'd1, 2'd2), stalled);
		check_count("read hit stall cycles", 1, stalled);
		expect_traffic("read hit", 0, 0);
	endtask

	task automatic write_hit_merge();
		cache_pkg::addr_t addr;
		int stalled;
		addr = make_addr(11'd5, 3'd1, 2'd0);
		mark_traffic();
		write_word(addr, cpu_view[addr] ^ 32'hffff_0000);
		// The written word changes while its three neighbours stay as fetched
		for (int i = 0; i < `CACHE_LINE_WORDS; i++)
			read_check("write hit", make_addr(11'd5, 3'd1, cache_pkg::offset_t'(i)), stalled);
		expect_traffic("write hit", 0, 0);
	endtask

	task automatic lru_replacement();
		int stalled;
		mark_traffic();
		read_check("lru fill", make_addr(11'd10, 3'd3, 2'd0), stalled);
		read_check("lru fill", make_addr(11'd20, 3'd3, 2'd1), stalled);
		// Touching tag 10 leaves tag 20 as the least recently used way
		read_check("lru touch", make_addr(11'd10, 3'd3, 2'd2), stalled);
		read_check("lru evict", make_addr(11'd30, 3'd3, 2'd0), stalled);
		expect_traffic("lru fills", 3, 0);
		mark_traffic();
		read_check("lru keep", make_addr(11'd10, 3'd3, 2'd3), stalled);
		expect_traffic("lru kept line", 0, 0);
		read_check("lru refetch", make_addr(11'd20, 3'd3, 2'd0), stalled);
		expect_traffic("lru evicted line", 1, 0);
	endtask

	task automatic dirty_eviction();
		cache_pkg::addr_t dirty_addr;
		int stalled;
		dirty_addr = make_addr(11'd40, 3'd5, 2'd1);
		read_check("dirty setup", dirty_addr, stalled);
		write_word(dirty_addr, cpu_view[dirty_addr] ^ 32'h0000_ffff);
		read_check("dirty setup", make_addr(11'd41, 3'd5, 2'd0), stalled);
		// Way 0 now holds the written line and is least recently used
		mark_traffic();
		read_check("dirty eviction", make_addr(11'd42, 3'd5, 2'd2), stalled);
		expect_traffic("dirty eviction", 1, 1);
		expect_writeback("dirty eviction", make_addr(11'd40, 3'd5, 2'd0));
	endtask

	task automatic write_miss_allocate();
		cache_pkg::addr_t addr;
		int stalled;
		addr = make_addr(11'd50, 3'd6, 2'd3);
		mark_traffic();
		write_word(addr, cpu_view[addr] ^ 32'h5a5a_5a5a);
		expect_traffic("write miss allocate", 1, 0);
		read_check("write miss readback", addr, stalled);
		read_check("write miss readback", make_addr(11'd50, 3'd6, 2'd0), stalled);
		expect_traffic("write miss hits", 1, 0);
		read_check("write miss evict", make_addr(11'd51, 3'd6, 2'd0), stalled);
		read_check("write miss evict", make_addr(11'd52, 3'd6, 2'd1), stalled);
		expect_traffic("write miss eviction", 3, 1);
		expect_writeback("write miss eviction", make_addr(11'd50, 3'd6, 2'd0));
	endtask

	initial
	begin
		rd_cpu = 1'b0;
		wr_cpu = 1'b0;
		addr_cpu = '0;
		wdata_cpu = '0;
		reset_n = 1'b0;
		fill_memory();
		repeat (4) @(negedge clock);
		reset_n = 1'b1;
		check_addr("after reset", '0, addr_mem);
		check_level("after reset stall", 1'b0, stall_cpu);
		check_level("after reset read strobe", 1'b0, rd_mem);
		check_level("after reset write strobe", 1'b0, wr_mem);
		read_miss_clean();
		read_hit_repeat();
		write_hit_merge();
		lru_replacement();
		dirty_eviction();
		write_miss_allocate();
		$display("Checks run: %0d, errors: %0d", check_total, error_count);
		if (error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- build.f
+incdir+hw
hw/cache_pkg.sv
hw/lookup_if.sv
hw/way_ram.sv
hw/tag_decode.sv
hw/line_buffer.sv
hw/cache_control.sv
hw/cache_2way.sv
tb/mem_model.sv
tb/cache_tb.sv
